// ==== rtl/switch_pkg.sv ====
package switch_pkg;

    localparam int NUM_PORTS         = 4;   // Input and output ports.
    localparam int NUM_SLOTS         = 16;  // Slots in the shared buffer.
    localparam int SLOT_WORDS        = 32;  // A packet fits in one slot.
    localparam int ALMOST_FULL_SLOTS = 4;   // Free count at or below which almost_full is set.
    localparam int QUEUE_DEPTH       = 16;  // Descriptors per priority queue.
    localparam int QPTR_W            = $clog2(QUEUE_DEPTH);

    // Header layout of the first word of a packet.
    localparam int HDR_DEST_LSB = 0;
    localparam int HDR_PRIO_BIT = 2;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  port_t;
    typedef logic [3:0]  slot_t;
    typedef logic [4:0]  addr_t;        // Word index inside a slot.
    typedef logic [5:0]  len_t;         // Length in words, 1 to 32.
    typedef logic        prio_t;        // 1 is high priority.
    typedef logic [4:0]  slot_count_t;  // Holds 0 to 16 free slots.

    // Rotating pick over the requests, starting the search at port start.
    // The scan runs from the farthest port back to start, so the last hit is the nearest.
    function automatic port_t rr_pick(input logic [NUM_PORTS-1:0] req, input port_t start);
        port_t idx;
        rr_pick = start;
        for (int i = 0; i < NUM_PORTS; i++) begin
            idx = start + port_t'(NUM_PORTS - 1 - i);
            if (req[idx]) rr_pick = idx;
        end
    endfunction

endpackage

// ==== rtl/switch_ifs.sv ====
`timescale 1ns/1ps

// Write path from one ingress into the shared buffer.
interface buf_wr_if;
    logic              en;    // One word is written on each cycle en is high.
    switch_pkg::slot_t slot;
    switch_pkg::addr_t addr;
    switch_pkg::word_t data;

    modport source (output en, slot, addr, data);
    modport sink   (input en, slot, addr, data);
endinterface

// Enqueue request of a finished packet.
// The requester holds req and the descriptor until grant.
interface enq_if;
    logic              req;
    logic              grant;  // One cycle, the descriptor is taken on this edge.
    switch_pkg::port_t dest;
    switch_pkg::prio_t prio;
    switch_pkg::slot_t slot;
    switch_pkg::len_t  len;

    modport requester (output req, dest, prio, slot, len, input grant);
    modport manager   (input req, dest, prio, slot, len, output grant);
endinterface

// Head descriptor of one output, high priority first.
interface deq_if;
    logic              pop;    // Pulsed only while valid is high.
    logic              valid;
    switch_pkg::slot_t slot;
    switch_pkg::len_t  len;

    modport manager  (input pop, output valid, slot, len);
    modport consumer (output pop, input valid, slot, len);
endinterface

// ==== rtl/ingress_port.sv ====
`timescale 1ns/1ps

module ingress_port (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_sop,
    input  logic              wr_eop,
    input  logic              wr_vld,
    input  switch_pkg::word_t wr_data,
    output logic              pause,
    output logic              alloc_req,
    input  logic              alloc_grant,
    input  switch_pkg::slot_t alloc_slot,
    buf_wr_if.source          buf_wr,
    enq_if.requester          enq
);

    logic              has_slot;  // A slot is reserved for the next packet.
    logic              enq_req;   // The finished packet waits for its enqueue.
    logic              take;
    switch_pkg::len_t  cnt_q;     // Words stored so far, it is the length at the end.
    switch_pkg::len_t  cnt_next;
    switch_pkg::slot_t slot_q;
    switch_pkg::port_t dest_q;
    switch_pkg::prio_t prio_q;

    assign take = wr_vld && has_slot;

    // The count restarts at the header and stops at a full slot.
    assign cnt_next = wr_sop ? switch_pkg::len_t'(1) :
                      (cnt_q == switch_pkg::len_t'(switch_pkg::SLOT_WORDS)) ? cnt_q : cnt_q + 1'b1;

    assign pause     = !has_slot;
    assign alloc_req = !has_slot && !enq_req;  // A new slot is asked for only after the enqueue.

    // Words beyond the 32nd are dropped.
    assign buf_wr.en   = take && (wr_sop || cnt_q != switch_pkg::len_t'(switch_pkg::SLOT_WORDS));
    assign buf_wr.slot = slot_q;
    assign buf_wr.addr = wr_sop ? '0 : switch_pkg::addr_t'(cnt_q);
    assign buf_wr.data = wr_data;

    assign enq.req  = enq_req;
    assign enq.dest = dest_q;
    assign enq.prio = prio_q;
    assign enq.slot = slot_q;
    assign enq.len  = cnt_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            has_slot <= 1'b0;
            enq_req  <= 1'b0;
            cnt_q    <= '0;
        end else begin
            if (alloc_grant) has_slot <= 1'b1;
            else if (take && wr_eop) has_slot <= 1'b0;  // Pause rises the cycle after the end.
            if (take && wr_eop) enq_req <= 1'b1;
            else if (enq.grant) enq_req <= 1'b0;
            if (take) cnt_q <= cnt_next;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_grant) slot_q <= alloc_slot;
        if (take && wr_sop) begin
            dest_q <= wr_data[switch_pkg::HDR_DEST_LSB +: $bits(switch_pkg::port_t)];
            prio_q <= wr_data[switch_pkg::HDR_PRIO_BIT];
        end
    end

endmodule

// ==== rtl/slot_allocator.sv ====
`timescale 1ns/1ps

module slot_allocator (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [switch_pkg::NUM_PORTS-1:0] alloc_req,
    output logic [switch_pkg::NUM_PORTS-1:0] alloc_grant,
    output switch_pkg::slot_t                alloc_slot,
    input  logic [switch_pkg::NUM_PORTS-1:0] rel_en,
    input  switch_pkg::slot_t                rel_slot [switch_pkg::NUM_PORTS],
    output logic                             full,
    output logic                             almost_full
);

    switch_pkg::slot_t       fifo [switch_pkg::NUM_SLOTS];  // Free slot numbers.
    switch_pkg::slot_t       head_q;
    switch_pkg::slot_t       tail_q;
    switch_pkg::slot_count_t count_q;
    switch_pkg::slot_count_t count_next;
    switch_pkg::slot_count_t rel_cnt;
    switch_pkg::slot_t       rel_pos [switch_pkg::NUM_PORTS];
    switch_pkg::port_t       rr_q;
    switch_pkg::port_t       winner;
    logic                    grant_any;

    // Releases of the same cycle land in consecutive entries after the tail.
    always_comb begin
        rel_cnt = '0;
        for (int k = 0; k < switch_pkg::NUM_PORTS; k++) begin
            rel_pos[k] = tail_q + switch_pkg::slot_t'(rel_cnt);
            rel_cnt    = rel_cnt + switch_pkg::slot_count_t'(rel_en[k]);
        end
    end

    assign winner     = switch_pkg::rr_pick(alloc_req, rr_q);
    assign grant_any  = |alloc_req && count_q != '0;  // Only the registered count is offered.
    assign alloc_slot = fifo[head_q];
    assign count_next = count_q - switch_pkg::slot_count_t'(grant_any) + rel_cnt;

    always_comb begin
        alloc_grant         = '0;
        alloc_grant[winner] = grant_any;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < switch_pkg::NUM_SLOTS; i++) fifo[i] <= switch_pkg::slot_t'(i);
            head_q      <= '0;
            tail_q      <= '0;  // All slots are free, so head equals tail.
            count_q     <= switch_pkg::slot_count_t'(switch_pkg::NUM_SLOTS);
            rr_q        <= '0;
            full        <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            for (int k = 0; k < switch_pkg::NUM_PORTS; k++) begin
                if (rel_en[k]) fifo[rel_pos[k]] <= rel_slot[k];
            end
            tail_q <= tail_q + switch_pkg::slot_t'(rel_cnt);
            if (grant_any) begin
                head_q <= head_q + 1'b1;
                rr_q   <= winner + 1'b1;  // The port after the winner goes first next time.
            end
            count_q     <= count_next;
            full        <= count_next == '0;
            almost_full <= count_next <= switch_pkg::slot_count_t'(switch_pkg::ALMOST_FULL_SLOTS);
        end
    end

endmodule

// ==== rtl/packet_buffer.sv ====
`timescale 1ns/1ps

module packet_buffer (
    input  logic              clk,
    buf_wr_if.sink            wr      [switch_pkg::NUM_PORTS],
    input  switch_pkg::slot_t rd_slot [switch_pkg::NUM_PORTS],
    input  switch_pkg::addr_t rd_addr [switch_pkg::NUM_PORTS],
    output switch_pkg::word_t rd_word [switch_pkg::NUM_PORTS]
);

    switch_pkg::word_t              mem [switch_pkg::NUM_SLOTS][switch_pkg::SLOT_WORDS];
    logic [switch_pkg::NUM_PORTS-1:0] wr_en;
    switch_pkg::slot_t              wr_slot [switch_pkg::NUM_PORTS];
    switch_pkg::addr_t              wr_addr [switch_pkg::NUM_PORTS];
    switch_pkg::word_t              wr_data [switch_pkg::NUM_PORTS];

    // The write ports are gathered into arrays so one process owns the storage.
    for (genvar p = 0; p < switch_pkg::NUM_PORTS; p++) begin : g_wr
        assign wr_en[p]   = wr[p].en;
        assign wr_slot[p] = wr[p].slot;
        assign wr_addr[p] = wr[p].addr;
        assign wr_data[p] = wr[p].data;
    end

    // Each ingress owns its slot, so two writes never meet on one word.
    always_ff @(posedge clk) begin
        for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
            if (wr_en[p]) mem[wr_slot[p]][wr_addr[p]] <= wr_data[p];
            rd_word[p] <= mem[rd_slot[p]][rd_addr[p]];  // Data returns one cycle after the address.
        end
    end

endmodule

// ==== rtl/queue_manager.sv ====
`timescale 1ns/1ps

module queue_manager (
    input logic     clk,
    input logic     rst_n,
    enq_if.manager  enq [switch_pkg::NUM_PORTS],
    deq_if.manager  deq [switch_pkg::NUM_PORTS]
);

    localparam int NQ = 2 * switch_pkg::NUM_PORTS;  // Queue index is {dest, prio}.

    logic [switch_pkg::NUM_PORTS-1:0] req;
    logic [switch_pkg::NUM_PORTS-1:0] grant;
    logic [switch_pkg::NUM_PORTS-1:0] pop;
    switch_pkg::port_t enq_dest [switch_pkg::NUM_PORTS];
    switch_pkg::prio_t enq_prio [switch_pkg::NUM_PORTS];
    switch_pkg::slot_t enq_slot [switch_pkg::NUM_PORTS];
    switch_pkg::len_t  enq_len  [switch_pkg::NUM_PORTS];
    switch_pkg::prio_t sel_prio [switch_pkg::NUM_PORTS];
    switch_pkg::slot_t q_slot [NQ][switch_pkg::QUEUE_DEPTH];
    switch_pkg::len_t  q_len  [NQ][switch_pkg::QUEUE_DEPTH];
    logic [switch_pkg::QPTR_W:0] wr_ptr [NQ];  // One extra bit tells full from empty.
    logic [switch_pkg::QPTR_W:0] rd_ptr [NQ];
    logic [NQ-1:0]     not_empty;
    logic [$clog2(NQ)-1:0] wq;
    switch_pkg::port_t rr_q;
    switch_pkg::port_t winner;
    logic              grant_any;

    for (genvar p = 0; p < switch_pkg::NUM_PORTS; p++) begin : g_port
        logic [$clog2(NQ)-1:0] hq;
        assign req[p]       = enq[p].req;
        assign enq[p].grant = grant[p];
        assign enq_dest[p]  = enq[p].dest;
        assign enq_prio[p]  = enq[p].prio;
        assign enq_slot[p]  = enq[p].slot;
        assign enq_len[p]   = enq[p].len;
        assign pop[p]       = deq[p].pop;
        assign sel_prio[p]  = not_empty[2*p+1];  // Strict priority, high queue first.
        assign hq           = {switch_pkg::port_t'(p), sel_prio[p]};
        assign deq[p].valid = not_empty[2*p+1] || not_empty[2*p];
        assign deq[p].slot  = q_slot[hq][rd_ptr[hq][switch_pkg::QPTR_W-1:0]];
        assign deq[p].len   = q_len[hq][rd_ptr[hq][switch_pkg::QPTR_W-1:0]];
    end

    for (genvar q = 0; q < NQ; q++) begin : g_q
        assign not_empty[q] = wr_ptr[q] != rd_ptr[q];
    end

    assign winner    = switch_pkg::rr_pick(req, rr_q);
    assign grant_any = |req;
    assign wq        = {enq_dest[winner], enq_prio[winner]};

    always_comb begin
        grant         = '0;
        grant[winner] = grant_any;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int q = 0; q < NQ; q++) begin
                wr_ptr[q] <= '0;
                rd_ptr[q] <= '0;
            end
            rr_q <= '0;
        end else begin
            if (grant_any) begin
                wr_ptr[wq] <= wr_ptr[wq] + 1'b1;
                rr_q       <= winner + 1'b1;
            end
            for (int o = 0; o < switch_pkg::NUM_PORTS; o++) begin
                if (pop[o]) begin
                    rd_ptr[{switch_pkg::port_t'(o), sel_prio[o]}] <=
                        rd_ptr[{switch_pkg::port_t'(o), sel_prio[o]}] + 1'b1;
                end
            end
        end
    end

    // The new entry shows at the head on the next cycle.
    always_ff @(posedge clk) begin
        if (grant_any) begin
            q_slot[wq][wr_ptr[wq][switch_pkg::QPTR_W-1:0]] <= enq_slot[winner];
            q_len[wq][wr_ptr[wq][switch_pkg::QPTR_W-1:0]]  <= enq_len[winner];
        end
    end

endmodule

// ==== rtl/egress_port.sv ====
`timescale 1ns/1ps

module egress_port (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ready,
    deq_if.consumer           deq,
    output switch_pkg::slot_t rd_slot,
    output switch_pkg::addr_t rd_addr,
    input  switch_pkg::word_t rd_word,
    output logic              rd_sop,
    output logic              rd_eop,
    output logic              rd_vld,
    output switch_pkg::word_t rd_data,
    output logic              rel_en,
    output switch_pkg::slot_t rel_slot
);

    typedef enum logic [1:0] {IDLE, READ, DRAIN} state_t;

    state_t            state;
    switch_pkg::slot_t slot_q;
    switch_pkg::len_t  len_q;
    switch_pkg::addr_t addr_q;
    logic              last;

    assign last    = switch_pkg::len_t'(addr_q) == len_q - switch_pkg::len_t'(1);
    assign deq.pop = state == IDLE && ready && deq.valid;  // Ready only starts a packet.

    assign rd_slot  = slot_q;
    assign rd_addr  = addr_q;
    assign rd_data  = rd_vld ? rd_word : '0;
    assign rel_en   = rd_eop;  // The slot goes back with the last word.
    assign rel_slot = slot_q;

    // The strobes are delayed one cycle to line up with the registered buffer read.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            rd_vld <= 1'b0;
            rd_sop <= 1'b0;
            rd_eop <= 1'b0;
        end else begin
            rd_vld <= state == READ;
            rd_sop <= state == READ && addr_q == '0;
            rd_eop <= state == READ && last;
            case (state)
                IDLE:    if (deq.pop) state <= READ;
                READ:    if (last) state <= DRAIN;
                DRAIN:   state <= IDLE;  // The last word is on the output now.
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (deq.pop) begin
            slot_q <= deq.slot;
            len_q  <= deq.len;
            addr_q <= '0;
        end else if (state == READ) begin
            addr_q <= addr_q + 1'b1;
        end
    end

endmodule

// ==== rtl/hydra_switch.sv ====
`timescale 1ns/1ps

module hydra_switch (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [switch_pkg::NUM_PORTS-1:0]         wr_sop,
    input  logic [switch_pkg::NUM_PORTS-1:0]         wr_eop,
    input  logic [switch_pkg::NUM_PORTS-1:0]         wr_vld,
    input  switch_pkg::word_t [switch_pkg::NUM_PORTS-1:0] wr_data,
    output logic [switch_pkg::NUM_PORTS-1:0]         pause,
    output logic                                     full,
    output logic                                     almost_full,
    input  logic [switch_pkg::NUM_PORTS-1:0]         ready,
    output logic [switch_pkg::NUM_PORTS-1:0]         rd_sop,
    output logic [switch_pkg::NUM_PORTS-1:0]         rd_eop,
    output logic [switch_pkg::NUM_PORTS-1:0]         rd_vld,
    output switch_pkg::word_t [switch_pkg::NUM_PORTS-1:0] rd_data
);

    logic [switch_pkg::NUM_PORTS-1:0] alloc_req;
    logic [switch_pkg::NUM_PORTS-1:0] alloc_grant;
    logic [switch_pkg::NUM_PORTS-1:0] rel_en;
    switch_pkg::slot_t                alloc_slot;  // Shared, only the granted port takes it.
    switch_pkg::slot_t                rel_slot [switch_pkg::NUM_PORTS];
    switch_pkg::slot_t                rd_slot  [switch_pkg::NUM_PORTS];
    switch_pkg::addr_t                rd_addr  [switch_pkg::NUM_PORTS];
    switch_pkg::word_t                rd_word  [switch_pkg::NUM_PORTS];

    buf_wr_if bw [switch_pkg::NUM_PORTS] ();
    enq_if    eq [switch_pkg::NUM_PORTS] ();
    deq_if    dq [switch_pkg::NUM_PORTS] ();

    for (genvar p = 0; p < switch_pkg::NUM_PORTS; p++) begin : g_port
        ingress_port u_ingress (
            .clk, .rst_n,
            .wr_sop(wr_sop[p]), .wr_eop(wr_eop[p]), .wr_vld(wr_vld[p]), .wr_data(wr_data[p]),
            .pause(pause[p]),
            .alloc_req(alloc_req[p]), .alloc_grant(alloc_grant[p]), .alloc_slot,
            .buf_wr(bw[p]), .enq(eq[p])
        );

        egress_port u_egress (
            .clk, .rst_n,
            .ready(ready[p]), .deq(dq[p]),
            .rd_slot(rd_slot[p]), .rd_addr(rd_addr[p]), .rd_word(rd_word[p]),
            .rd_sop(rd_sop[p]), .rd_eop(rd_eop[p]), .rd_vld(rd_vld[p]), .rd_data(rd_data[p]),
            .rel_en(rel_en[p]), .rel_slot(rel_slot[p])
        );
    end

    slot_allocator u_alloc (
        .clk, .rst_n,
        .alloc_req, .alloc_grant, .alloc_slot,
        .rel_en, .rel_slot,
        .full, .almost_full
    );

    packet_buffer u_buf (.clk, .wr(bw), .rd_slot, .rd_addr, .rd_word);

    queue_manager u_qm (.clk, .rst_n, .enq(eq), .deq(dq));

endmodule

// ==== bench/switch_checker.sv ====
`timescale 1ns/1ps

module switch_checker (
    input logic                             clk,
    input logic                             rst_n,
    input logic [switch_pkg::NUM_PORTS-1:0] rd_sop,
    input logic [switch_pkg::NUM_PORTS-1:0] rd_eop,
    input logic [switch_pkg::NUM_PORTS-1:0] rd_vld,
    input logic                             full,
    input logic                             almost_full
);

    logic [switch_pkg::NUM_PORTS-1:0] in_pkt;  // Set between rd_sop and rd_eop of a port.

    // A one-word packet has sop and eop together and never opens a frame.
    always_ff @(posedge clk) begin
        if (!rst_n) in_pkt <= '0;
        else in_pkt <= (in_pkt | rd_sop) & ~rd_eop;
    end

    // The read strobes stay low while reset is held.
    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> (rd_sop | rd_eop | rd_vld) == '0)
        else $error("read strobe high during reset");

    // Frame markers only come with a valid word.
    a_marker_valid: assert property (@(posedge clk) disable iff (!rst_n)
        ((rd_sop | rd_eop) & ~rd_vld) == '0)
        else $error("rd_sop or rd_eop without rd_vld");

    a_no_nested_sop: assert property (@(posedge clk) disable iff (!rst_n)
        (in_pkt & rd_sop) == '0)
        else $error("second rd_sop before rd_eop");

    // No free slot also means the low-water mark was crossed.
    a_full_implies_af: assert property (@(posedge clk) disable iff (!rst_n)
        full |-> almost_full)
        else $error("full without almost_full");

endmodule

// ==== bench/switch_tb.sv ====
`timescale 1ns/1ps

module switch_tb;

    localparam int MAX_PKTS   = 64;
    localparam int DOG_CYCLES = 200;  // Watchdog budget per packet.

    logic clk;
    logic rst_n;
    logic [3:0] wr_sop, wr_eop, wr_vld, pause, ready, rd_sop, rd_eop, rd_vld;
    logic full, almost_full;
    switch_pkg::word_t [3:0] wr_data, rd_data;

    int  npkt, sent_cnt, rx_cnt, cycle, errors;
    int  rel_cycle [4];  // Cycle from which ready of a port is high again.
    int  vsrc [MAX_PKTS], vdest [MAX_PKTS], vprio [MAX_PKTS];
    int  vlen [MAX_PKTS], vtag [MAX_PKTS], vhold [MAX_PKTS];
    bit  sent [MAX_PKTS], started [MAX_PKTS];
    time eop_time [MAX_PKTS];
    int  flow_q [32][$];  // Packet numbers per {src, dest, prio} in send order.
    int  rx_n [4], rx_i [4];
    bit  open_frame [4];  // A packet is being received on the port.
    bit  full_seen, af_seen, pause_all_seen;

    hydra_switch dut_i (.*);

    bind hydra_switch switch_checker chk_i (.*);

    always #5 clk = ~clk;

    // Header is {tag, src, 000, prio, dest}; payload is {src, tag, index}.
    function automatic switch_pkg::word_t make_word(int n, int i);
        if (i == 0) make_word = {8'(vtag[n]), 2'(vsrc[n]), 3'b000, 1'(vprio[n]), 2'(vdest[n])};
        else make_word = {2'(vsrc[n]), 6'(vtag[n]), 8'(i)};
    endfunction

    function automatic int flow_of(int s, int d, int pr);
        flow_of = s * 8 + d * 2 + pr;
    endfunction

    task automatic check(int expv, int act, string msg);
        if (expv !== act) begin
            errors++;
            $display("mismatch at %0d ns: %s, expected %0d, got %0d", $time, msg, expv, act);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // One clock; ready follows the hold deadlines of the ports.
    task automatic tick();
        @(posedge clk);
        cycle++;
        for (int p = 0; p < 4; p++) ready[p] <= cycle >= rel_cycle[p];
    endtask

    task automatic read_vectors();
        int    fd, r, s, d, pr, l, t, h;
        string line;
        fd = $fopen("bench/switch_vectors.txt", "r");
        if (fd == 0) begin
            $display("The vector file bench/switch_vectors.txt could not be opened");
            $display("Verification failed");
            $fatal(1);
        end
        r = $fgets(line, fd);  // Two comment lines describe the columns.
        r = $fgets(line, fd);
        while (!$feof(fd) && npkt < MAX_PKTS) begin
            r = $fscanf(fd, " %d %d %d %d %d %d", s, d, pr, l, t, h);
            if (r != 6) break;
            vsrc[npkt]  = s;
            vdest[npkt] = d;
            vprio[npkt] = pr;
            vlen[npkt]  = l;
            vtag[npkt]  = t;
            vhold[npkt] = h;
            npkt++;
        end
        $fclose(fd);
        if (npkt == 0) begin
            $display("The vector file holds no packets");
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic send_packet(int n);
        int s;
        s = vsrc[n];
        if (vhold[n] > 0) rel_cycle[vdest[n]] = 1 << 30;  // Stall the output while sending.
        flow_q[flow_of(s, vdest[n], vprio[n])].push_back(n);
        tick();
        while (pause[s]) tick();  // A packet starts only while pause is low.
        for (int i = 0; i < vlen[n]; i++) begin
            if (i > 0) tick();
            wr_sop[s]  <= i == 0;
            wr_eop[s]  <= i == vlen[n] - 1;
            wr_vld[s]  <= 1'b1;
            wr_data[s] <= make_word(n, i);
        end
        tick();  // The switch takes the last word on this edge.
        wr_sop[s] <= 1'b0;
        wr_eop[s] <= 1'b0;
        wr_vld[s] <= 1'b0;
        eop_time[n] = $time;
        sent[n]     = 1'b1;
        sent_cnt++;
        if (vhold[n] > 0) rel_cycle[vdest[n]] = cycle + vhold[n];
    endtask

    task automatic drain();
        while (rx_cnt != sent_cnt) tick();
    endtask

    // Outputs are sampled on the falling edge, away from the updates.
    always @(negedge clk) begin
        int                n, fl, late;
        switch_pkg::word_t hdr;
        if (rst_n) begin
            if (full && !full_seen) begin
                check(1, int'(af_seen), "almost_full had not risen before full");
                full_seen = 1'b1;
            end
            if (almost_full) af_seen = 1'b1;
            if (full && pause == 4'hf) pause_all_seen = 1'b1;
            for (int p = 0; p < 4; p++) begin
                // The words of one packet come back to back.
                if (open_frame[p]) check(1, int'(rd_vld[p]), "gap in the words of a packet");
                if (rd_vld[p]) begin
                    if (rd_sop[p]) begin
                        hdr = rd_data[p];
                        check(p, int'(hdr[1:0]), "packet left at the wrong output");
                        fl = flow_of(hdr[7:6], hdr[1:0], hdr[2]);
                        check(1, int'(flow_q[fl].size() > 0), "packet of a flow with none pending");
                        n = flow_q[fl].pop_front();
                        started[n]    = 1'b1;
                        rx_n[p]       = n;
                        rx_i[p]       = 0;
                        open_frame[p] = 1'b1;
                        check(vtag[n], int'(hdr[15:8]), "sequence tag out of flow order");
                        if (!hdr[2]) begin
                            late = 0;  // High packets queued well before this start.
                            for (int m = 0; m < npkt; m++) begin
                                if (vdest[m] == p && vprio[m] == 1 && sent[m] && !started[m] &&
                                    $time > eop_time[m] + 80) late++;
                            end
                            check(0, late, "low priority packet left before a queued high one");
                        end
                    end else begin
                        check(1, int'(open_frame[p]), "valid word outside a packet");
                    end
                    n = rx_n[p];
                    check(make_word(n, rx_i[p]), rd_data[p], "packet word");
                    if (rd_eop[p]) begin
                        check(vlen[n], rx_i[p] + 1, "packet length");
                        open_frame[p] = 1'b0;
                        rx_cnt++;
                    end
                    rx_i[p]++;
                end
            end
        end
    end

    initial begin
        wait (npkt > 0);
        #(npkt * DOG_CYCLES * 10 + 100);
        $display("Timeout: the switch did not deliver every packet in time");
        $display("Verification failed");
        $fatal(1);
    end

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        wr_sop  = '0;
        wr_eop  = '0;
        wr_vld  = '0;
        wr_data = '0;
        ready   = '1;
        for (int p = 0; p < 4; p++) rel_cycle[p] = 0;
        read_vectors();
        repeat (8) tick();
        rst_n <= 1'b1;
        // A change of the hold column starts a new group on an empty switch.
        for (int n = 0; n < npkt; n++) begin
            if (n > 0 && vhold[n] != vhold[n-1]) drain();
            send_packet(n);
        end
        drain();
        repeat (4) tick();
        check(1, int'(full_seen), "full never rose with every output stalled");
        check(1, int'(pause_all_seen), "pause was not high on every port while full");
        check(0, int'(full), "full still high after the drain");
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== bench/switch_vectors.txt ====
# src dest prio len tag hold, one packet per line, decimal
# hold is the number of cycles ready of dest stays low after the packet
0 1 0 5 1 0
1 2 1 32 2 0
2 3 0 1 3 0
3 0 1 8 4 0
0 1 0 3 5 0
2 1 0 7 6 0
1 3 0 6 7 40
2 3 1 4 8 40
0 1 0 4 9 200
1 2 1 5 10 200
2 3 0 6 11 200
3 0 1 4 12 200
0 2 1 5 13 200
1 3 0 6 14 200
2 0 1 4 15 200
3 1 0 5 16 200
0 3 0 6 17 200
1 0 1 4 18 200
2 1 0 5 19 200
3 2 1 6 20 200
0 0 1 4 21 200
1 1 0 5 22 200
2 2 1 6 23 200
3 3 0 4 24 200

// ==== all.f ====
rtl/switch_pkg.sv
rtl/switch_ifs.sv
rtl/ingress_port.sv
rtl/slot_allocator.sv
rtl/packet_buffer.sv
rtl/queue_manager.sv
rtl/egress_port.sv
rtl/hydra_switch.sv
bench/switch_checker.sv
bench/switch_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module switch_tb -Mdir obj_dir -o switch_sim

out=$(./obj_dir/switch_sim 2>&1) || true
echo "$out"
echo "$out" | grep -qx "Verification passed"
